/* Bender.yml */
package:
  name: rv_wb_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_core_pkg.sv
      - hw/wb_select.sv
      - hw/pc_redirect.sv
      - hw/reg_file.sv
      - hw/wb_stage.sv
  - target: simulation
    include_dirs:
      - hw
      - verification
    files:
      - verification/wb_stage_tb.sv

/* hw/pc_redirect.sv */
`timescale 1ns/100ps

`include "rv_core_cfg.svh"

module pc_redirect
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  valid,
    input  logic  br_flg,
    input  logic  jmp_flg,
    input  logic  ecall,
    input  word_t pc,
    input  word_t br_target,
    input  word_t alu_out,
    input  word_t trap_vector,
    output word_t next_pc,
    output logic  redirect,
    output logic  halted
);

    word_t pc_plus4;

    assign pc_plus4 = pc + word_t'(4);

    // Branch wins over jump, jump over ecall.
    always_comb begin
        if (valid && br_flg) begin
            next_pc = br_target;
        end else if (valid && jmp_flg) begin
            // Jump target comes from the ALU.
            next_pc = alu_out;
        end else if (valid && ecall) begin
            next_pc = trap_vector;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // Front end must flush on any taken control transfer.
    assign redirect = valid && (br_flg || jmp_flg || ecall);

    // Sticky until reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (valid && (pc == `RV_EXIT_PC)) begin
            halted <= 1'b1;
        end
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

`include "rv_core_cfg.svh"

module reg_file
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    localparam reg_idx_t SP_IDX = reg_idx_t'(2);

    word_t regs [`RV_NREGS];
    logic  wr_live;

    // Writes to x0 are discarded.
    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
            regs[SP_IDX] <= `RV_STACK_INIT;
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Read with x0 forced to zero and same-cycle forwarding.
    function automatic word_t read_port(input reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (wr_live && (wr_addr == idx)) begin
            data = wr_data;
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
    end

    always_comb begin
        rs2_data = read_port(rs2);
    end

endmodule

/* hw/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data and address width of the core.
`define RV_XLEN 32

// Architectural integer registers.
`define RV_NREGS 32

// Retiring at this address stops the core.
`define RV_EXIT_PC 32'h0000_1000

// Reset value of the stack pointer, x2.
`define RV_STACK_INIT 32'd1000

`endif

/* hw/rv_core_pkg.sv */
`include "rv_core_cfg.svh"

package rv_core_pkg;

    // Machine word, used for PCs and register data.
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register index, wide enough for every architectural register.
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    // Write-back source select.
    // Codes 8 to 15 are unused and fall back to the ALU result.
    typedef enum logic [3:0] {
        // ALU result.
        WB_ALU   = 4'd0,
        // Load byte, sign extended.
        WB_MEMB  = 4'd1,
        // Load byte, zero extended.
        WB_MEMBU = 4'd2,
        // Load halfword, sign extended.
        WB_MEMH  = 4'd3,
        // Load halfword, zero extended.
        WB_MEMHU = 4'd4,
        // Load word.
        WB_MEMW  = 4'd5,
        // Link address for jal and jalr.
        WB_PC    = 4'd6,
        // CSR read data.
        WB_CSR   = 4'd7
    } wb_sel_e;

endpackage

/* hw/wb_select.sv */
`timescale 1ns/100ps

`include "rv_core_cfg.svh"

module wb_select
    import rv_core_pkg::*;
(
    input  logic     valid,
    input  logic     rf_wen,
    input  wb_sel_e  wb_sel,
    input  reg_idx_t rd,
    input  word_t    pc,
    input  word_t    alu_out,
    input  word_t    mem_rdata,
    input  word_t    csr_rdata,
    output logic     wr_en,
    output reg_idx_t wr_addr,
    output word_t    wr_data
);

    word_t pc_plus4;
    word_t wb_data;

    // Link address for jumps.
    assign pc_plus4 = pc + word_t'(4);

    // Load data arrives right aligned from the memory stage.
    always_comb begin
        case (wb_sel)
            WB_MEMB: begin
                wb_data = {{(`RV_XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
            end
            WB_MEMBU: begin
                wb_data = {{(`RV_XLEN-8){1'b0}}, mem_rdata[7:0]};
            end
            WB_MEMH: begin
                wb_data = {{(`RV_XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
            end
            WB_MEMHU: begin
                wb_data = {{(`RV_XLEN-16){1'b0}}, mem_rdata[15:0]};
            end
            WB_MEMW: begin
                wb_data = mem_rdata;
            end
            WB_PC: begin
                wb_data = pc_plus4;
            end
            WB_CSR: begin
                wb_data = csr_rdata;
            end
            default: begin
                wb_data = alu_out;
            end
        endcase
    end

    // Write request for the register file; x0 is dropped there.
    assign wr_en   = valid && rf_wen;
    assign wr_addr = rd;
    assign wr_data = wb_data;

endmodule

/* hw/wb_stage.sv */
`timescale 1ns/100ps

`include "rv_core_cfg.svh"

module wb_stage
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     valid,
    input  word_t    pc,
    input  wb_sel_e  wb_sel,
    input  word_t    alu_out,
    input  word_t    mem_rdata,
    input  word_t    csr_rdata,
    input  reg_idx_t rd,
    input  logic     rf_wen,
    input  logic     br_flg,
    input  word_t    br_target,
    input  logic     jmp_flg,
    input  logic     ecall,
    input  word_t    trap_vector,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    output word_t    next_pc,
    output logic     redirect,
    output logic     halted
);

    // Write request from the select logic.
    logic     wr_en;
    reg_idx_t wr_addr;
    word_t    wr_data;

    wb_select u_wb_select (
        .valid     (valid),
        .rf_wen    (rf_wen),
        .wb_sel    (wb_sel),
        .rd        (rd),
        .pc        (pc),
        .alu_out   (alu_out),
        .mem_rdata (mem_rdata),
        .csr_rdata (csr_rdata),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    pc_redirect u_pc_redirect (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .br_flg      (br_flg),
        .jmp_flg     (jmp_flg),
        .ecall       (ecall),
        .pc          (pc),
        .br_target   (br_target),
        .alu_out     (alu_out),
        .trap_vector (trap_vector),
        .next_pc     (next_pc),
        .redirect    (redirect),
        .halted      (halted)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

/* verification/wb_stage_ref.svh */
`ifndef WB_STAGE_REF_SVH
`define WB_STAGE_REF_SVH

`include "rv_core_cfg.svh"

// Unknown select codes give the ALU result.
function automatic logic [`RV_XLEN-1:0] ref_wb_data(
    input logic [3:0]          sel,
    input logic [`RV_XLEN-1:0] pc,
    input logic [`RV_XLEN-1:0] alu,
    input logic [`RV_XLEN-1:0] mem,
    input logic [`RV_XLEN-1:0] csr
);
    logic [`RV_XLEN-1:0] result;
    case (sel)
        4'd1: result = `RV_XLEN'($signed(mem[7:0]));
        4'd2: result = `RV_XLEN'(mem[7:0]);
        4'd3: result = `RV_XLEN'($signed(mem[15:0]));
        4'd4: result = `RV_XLEN'(mem[15:0]);
        4'd5: result = mem;
        4'd6: result = pc + 4;
        4'd7: result = csr;
        default: result = alu;
    endcase
    return result;
endfunction

// Branch first, then jump, then ecall.
function automatic logic [`RV_XLEN-1:0] ref_next_pc(
    input logic                valid,
    input logic                br,
    input logic                jmp,
    input logic                ecall,
    input logic [`RV_XLEN-1:0] pc,
    input logic [`RV_XLEN-1:0] br_target,
    input logic [`RV_XLEN-1:0] jmp_target,
    input logic [`RV_XLEN-1:0] trap_vector
);
    logic [`RV_XLEN-1:0] target;
    target = pc + 4;
    if (valid) begin
        if (br) begin
            target = br_target;
        end else if (jmp) begin
            target = jmp_target;
        end else if (ecall) begin
            target = trap_vector;
        end
    end
    return target;
endfunction

function automatic logic ref_redirect(
    input logic valid,
    input logic br,
    input logic jmp,
    input logic ecall
);
    return valid & (br | jmp | ecall);
endfunction

// Only the stack pointer has a non-zero reset value.
function automatic logic [`RV_XLEN-1:0] ref_reset_value(input int idx);
    logic [`RV_XLEN-1:0] value;
    value = '0;
    if (idx == 2) begin
        value = `RV_STACK_INIT;
    end
    return value;
endfunction

`endif

/* verification/wb_stage_tb.sv */
`timescale 1ns/100ps

`include "rv_core_cfg.svh"

module wb_stage_tb
    import rv_core_pkg::*;
();

    // The tests take about 760 cycles.
    localparam int CYCLE_LIMIT = 2000;
    localparam int RANDOM_COUNT = 400;

    `include "wb_stage_ref.svh"

    logic     clk;
    logic     rst;
    logic     valid;
    word_t    pc;
    wb_sel_e  wb_sel;
    word_t    alu_out;
    word_t    mem_rdata;
    word_t    csr_rdata;
    reg_idx_t rd;
    logic     rf_wen;
    logic     br_flg;
    word_t    br_target;
    logic     jmp_flg;
    logic     ecall;
    word_t    trap_vector;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    next_pc;
    logic     redirect;
    logic     halted;

    word_t    shadow [`RV_NREGS];
    logic     halt_exp;
    integer   seed;
    int       errors;
    int       tests_run;
    int       tests_failed;
    int       test_start_errors;
    int       cycles;
    reg_idx_t other_idx;

    wb_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Shadow registers and halt flag follow the retire rules.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                shadow[i] <= ref_reset_value(i);
            end
            halt_exp <= 1'b0;
        end else begin
            if (valid && rf_wen && (rd != '0)) begin
                shadow[rd] <= ref_wb_data(wb_sel, pc, alu_out, mem_rdata, csr_rdata);
            end
            if (valid && (pc == `RV_EXIT_PC)) begin
                halt_exp <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // x0 reads zero and a write in flight is forwarded.
    function automatic word_t model_read(input reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (valid && rf_wen && (rd == idx)) begin
            data = ref_wb_data(wb_sel, pc, alu_out, mem_rdata, csr_rdata);
        end else begin
            data = shadow[idx];
        end
        return data;
    endfunction

    // Outputs are stable mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            if (rs1_data !== model_read(rs1)) begin
                $display("FAIL rs1_data x%0d: expected %h, got %h", rs1, model_read(rs1),
                         rs1_data);
                errors++;
            end
            if (rs2_data !== model_read(rs2)) begin
                $display("FAIL rs2_data x%0d: expected %h, got %h", rs2, model_read(rs2),
                         rs2_data);
                errors++;
            end
            if (next_pc !== ref_next_pc(valid, br_flg, jmp_flg, ecall, pc, br_target,
                                        alu_out, trap_vector)) begin
                $display("FAIL next_pc: expected %h, got %h", ref_next_pc(valid, br_flg,
                         jmp_flg, ecall, pc, br_target, alu_out, trap_vector), next_pc);
                errors++;
            end
            if (redirect !== ref_redirect(valid, br_flg, jmp_flg, ecall)) begin
                $display("FAIL redirect: expected %h, got %h",
                         ref_redirect(valid, br_flg, jmp_flg, ecall), redirect);
                errors++;
            end
            if (halted !== halt_exp) begin
                $display("FAIL halted: expected %h, got %h", halt_exp, halted);
                errors++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_idle();
        valid = 1'b0;
        rf_wen = 1'b0;
        br_flg = 1'b0;
        jmp_flg = 1'b0;
        ecall = 1'b0;
        wb_sel = WB_ALU;
    endtask

    task automatic drive_random_data();
        pc = $random(seed);
        alu_out = $random(seed);
        mem_rdata = $random(seed);
        csr_rdata = $random(seed);
        br_target = $random(seed);
        trap_vector = $random(seed);
    endtask

    task automatic pick_nonzero_idx(output reg_idx_t idx);
        idx = reg_idx_t'(($unsigned($random(seed)) % 31) + 1);
    endtask

    task automatic drive_random_instr();
        drive_random_data();
        {br_flg, jmp_flg, ecall} = 3'($random(seed));
        rf_wen = 1'($random(seed));
        wb_sel = wb_sel_e'($random(seed));
        pick_nonzero_idx(rd);
        valid = 1'b1;
    endtask

    task automatic apply_reset();
        next_cycle();
        drive_idle();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic end_test(input string name);
        int test_errors;
        next_cycle();
        drive_idle();
        test_errors = errors - test_start_errors;
        test_start_errors = errors;
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%-20s %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
    endtask

    initial begin
        seed = 32'h20de;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_start_errors = 0;
        cycles = 0;
        rst = 1'b1;
        drive_idle();
        pc = '0;
        alu_out = '0;
        mem_rdata = '0;
        csr_rdata = '0;
        br_target = '0;
        trap_vector = '0;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Both ports sweep every index, in opposite order.
        for (int i = 0; i < `RV_NREGS; i++) begin
            next_cycle();
            rs1 = reg_idx_t'(i);
            rs2 = reg_idx_t'(`RV_NREGS - 1 - i);
        end
        end_test("reset values");

        // Bit 0 of k sets the byte sign, bit 1 the halfword sign.
        for (int code = 0; code < 16; code++) begin
            for (int k = 0; k < 4; k++) begin
                next_cycle();
                drive_random_data();
                mem_rdata[7] = k[0];
                mem_rdata[15] = k[1];
                pick_nonzero_idx(rd);
                wb_sel = wb_sel_e'(code);
                valid = 1'b1;
                rf_wen = 1'b1;
                rs1 = '0;
                next_cycle();
                drive_idle();
                rs1 = rd;
                rs2 = rd;
            end
        end
        end_test("write-back select");

        for (int k = 0; k < 24; k++) begin
            next_cycle();
            drive_random_data();
            pick_nonzero_idx(rd);
            valid = (k % 3) != 1;
            rf_wen = (k % 3) != 0;
            if (k % 3 == 2) begin
                rd = '0;
            end
            rs1 = '0;
            rs2 = rd;
            next_cycle();
            drive_idle();
            rs1 = rd;
            rs2 = '0;
        end
        end_test("blocked writes");

        for (int k = 0; k < 16; k++) begin
            next_cycle();
            drive_random_data();
            pick_nonzero_idx(rd);
            pick_nonzero_idx(other_idx);
            if (other_idx == rd) begin
                other_idx = rd ^ 5'd1;
            end
            wb_sel = wb_sel_e'(k % 8);
            valid = 1'b1;
            rf_wen = 1'b1;
            rs1 = k[0] ? other_idx : rd;
            rs2 = k[0] ? rd : other_idx;
        end
        end_test("write bypass");

        // Every fourth instruction is followed by an idle cycle.
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            next_cycle();
            drive_random_instr();
            rs1 = rd;
            rs2 = reg_idx_t'($random(seed));
            if (n % 4 == 3) begin
                next_cycle();
                drive_random_data();
                valid = 1'b0;
            end
        end
        end_test("next pc");

        apply_reset();
        next_cycle();
        drive_random_data();
        pc = `RV_EXIT_PC;
        next_cycle();
        drive_idle();
        next_cycle();
        drive_random_data();
        pc = `RV_EXIT_PC;
        valid = 1'b1;
        for (int n = 0; n < 20; n++) begin
            next_cycle();
            drive_random_instr();
        end
        apply_reset();
        next_cycle();
        end_test("halt flag");

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
+incdir+verification
hw/rv_core_pkg.sv
hw/wb_select.sv
hw/pc_redirect.sv
hw/reg_file.sv
hw/wb_stage.sv
verification/wb_stage_tb.sv
